// ==== design/cpuPkg.sv ====
package cpuPkg;

	localparam int dataWidth = 32;
	localparam int addrWidth = 9; // 512-word memory
	localparam int regCount = 16;
	localparam int regSelWidth = 4;

	typedef enum logic [4:0] {
		opLd = 5'd0,
		opSt = 5'd2,
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opAddi = 5'd12,
		opHalt = 5'd28
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluPassB
	} aluOpT;

	typedef union packed {
		struct packed {
			opcodeT opcode;
			logic [regSelWidth-1:0] ra;
			logic [regSelWidth-1:0] rb;
			logic [regSelWidth-1:0] rc;
			logic [14:0] unused;
		} rFormat;
		struct packed {
			opcodeT opcode;
			logic [regSelWidth-1:0] ra;
			logic [regSelWidth-1:0] rb;
			logic [18:0] c; // Sign-extended constant
		} iFormat;
	} instrWord;

	localparam logic [4:0] regCtrl = 5'h00;
	localparam logic [4:0] regStatus = 5'h04;
	localparam logic [4:0] regStartPc = 5'h08;
	localparam logic [4:0] regMemAddr = 5'h0C;
	localparam logic [4:0] regMemData = 5'h10;
	localparam logic [4:0] regRegSel = 5'h14;
	localparam logic [4:0] regRegData = 5'h18;

endpackage

// ==== design/registerFile.sv ====
`timescale 1ns/100ps

module registerFile (
	input logic Clock,
	input logic rst,
	input logic regIn,
	input logic baOut,
	input logic [cpuPkg::regSelWidth-1:0] writeSel,
	input logic [cpuPkg::regSelWidth-1:0] readSel,
	input logic [cpuPkg::regSelWidth-1:0] hostSel,
	input logic [cpuPkg::dataWidth-1:0] busIn,
	output logic [cpuPkg::dataWidth-1:0] readData,
	output logic [cpuPkg::dataWidth-1:0] hostData
);
	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int i = 0; i < cpuPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (regIn) begin
			regs[writeSel] <= busIn;
		end
	end

	always_comb begin
		if (baOut && readSel == '0) begin
			readData = '0; // Base addressing sees R0 as zero
		end else begin
			readData = regs[readSel];
		end
	end

	assign hostData = regs[hostSel];

endmodule

// ==== design/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit (
	input cpuPkg::aluOpT op,
	input logic [cpuPkg::dataWidth-1:0] a,
	input logic [cpuPkg::dataWidth-1:0] b,
	output logic [cpuPkg::dataWidth-1:0] result
);

	always_comb begin
		case (op)
			cpuPkg::aluAdd: result = a + b;
			cpuPkg::aluSub: result = a - b; // Y minus the bus
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr: result = a | b;
			cpuPkg::aluPassB: result = b;
			default: result = b;
		endcase
	end

endmodule

// ==== design/busDatapath.sv ====
`timescale 1ns/100ps

module busDatapath (
	input logic Clock,
	input logic rst,
	input logic pcIn, irIn, marIn, mdrIn, yIn, zIn,
	input logic pcOut, mdrOut, zOut, cOut, regOut,
	input logic regIn, gra, grb, grc, baOut,
	input logic memRead, memWrite, incPc,
	input cpuPkg::aluOpT aluOp,
	input logic startLoad,
	input logic [cpuPkg::addrWidth-1:0] startPc,
	input logic [cpuPkg::dataWidth-1:0] memData,
	input logic [cpuPkg::regSelWidth-1:0] regSel,
	output logic [cpuPkg::addrWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] mdrValue,
	output logic [cpuPkg::dataWidth-1:0] regData,
	output cpuPkg::instrWord ir
);
	logic [cpuPkg::addrWidth-1:0] pc;
	logic [cpuPkg::addrWidth-1:0] mar;
	logic [cpuPkg::dataWidth-1:0] mdr;
	logic [cpuPkg::dataWidth-1:0] mdrNext;
	logic [cpuPkg::dataWidth-1:0] y;
	logic [cpuPkg::dataWidth-1:0] z;
	logic [cpuPkg::dataWidth-1:0] bus;
	logic [cpuPkg::dataWidth-1:0] aluA;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic [cpuPkg::dataWidth-1:0] regRead;
	logic [cpuPkg::dataWidth-1:0] cValue;
	logic [cpuPkg::regSelWidth-1:0] regNum;

	always_comb begin
		if (gra) regNum = ir.rFormat.ra;
		else if (grb) regNum = ir.rFormat.rb;
		else if (grc) regNum = ir.rFormat.rc;
		else regNum = '0;
	end

	assign cValue = $signed(ir.iFormat.c);

	// The sequencer raises at most one source per cycle
	always_comb begin
		bus = '0;
		if (pcOut) bus[cpuPkg::addrWidth-1:0] = pc;
		else if (mdrOut) bus = mdr;
		else if (zOut) bus = z;
		else if (cOut) bus = cValue;
		else if (regOut) bus = regRead;
	end

	assign aluA = incPc ? 1 : y; // Fetch adds one to PC
	assign mdrNext = memRead ? memData : bus;
	assign mdrValue = (memWrite && mdrIn) ? mdrNext : mdr; // St writes the word MDR takes
	assign memAddr = mar;

	always_ff @(posedge Clock) begin
		if (rst) begin
			pc <= '0;
		end else if (startLoad) begin
			pc <= startPc;
		end else if (pcIn) begin
			pc <= bus[cpuPkg::addrWidth-1:0];
		end
	end

	always_ff @(posedge Clock) begin
		if (marIn) mar <= bus[cpuPkg::addrWidth-1:0];
		if (mdrIn) mdr <= mdrNext;
		if (irIn) ir <= bus;
		if (yIn) y <= bus;
		if (zIn) z <= aluResult;
	end

	registerFile u_regs (
		.Clock(Clock),
		.rst(rst),
		.regIn(regIn),
		.baOut(baOut),
		.writeSel(regNum),
		.readSel(regNum),
		.hostSel(regSel),
		.busIn(bus),
		.readData(regRead),
		.hostData(regData)
	);

	aluUnit u_alu (
		.op(aluOp),
		.a(aluA),
		.b(bus),
		.result(aluResult)
	);

endmodule

// ==== design/controlSequencer.sv ====
`timescale 1ns/100ps

module controlSequencer (
	input logic Clock,
	input logic rst,
	input logic start,
	input cpuPkg::instrWord ir,
	output logic pcIn, irIn, marIn, mdrIn, yIn, zIn,
	output logic pcOut, mdrOut, zOut, cOut, regOut,
	output logic regIn, gra, grb, grc, baOut,
	output logic memRead, memWrite, incPc,
	output cpuPkg::aluOpT aluOp,
	output logic busy,
	output logic halted
);
	logic [2:0] tState; // Meaningful only while busy
	logic memOp;
	logic useConst;
	logic lastStep;
	cpuPkg::opcodeT opcode;
	cpuPkg::aluOpT execOp;

	assign opcode = ir.rFormat.opcode;
	assign memOp = opcode inside {cpuPkg::opLd, cpuPkg::opSt};
	assign useConst = memOp || opcode == cpuPkg::opAddi; // The iFormat instructions

	always_comb begin
		case (opcode)
			cpuPkg::opSub: execOp = cpuPkg::aluSub;
			cpuPkg::opAnd: execOp = cpuPkg::aluAnd;
			cpuPkg::opOr: execOp = cpuPkg::aluOr;
			default: execOp = cpuPkg::aluAdd; // Add, addi and the ld/st address sum
		endcase
		case (opcode)
			cpuPkg::opLd: lastStep = tState == 3'd7;
			cpuPkg::opSt: lastStep = tState == 3'd6;
			cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opAddi:
				lastStep = tState == 3'd5;
			default: lastStep = tState == 3'd3; // Unknown opcodes pass as no-ops
		endcase
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			busy <= 1'b0;
			halted <= 1'b0;
			tState <= '0;
		end else if (!busy) begin
			if (start) begin
				busy <= 1'b1;
				halted <= 1'b0;
				tState <= '0;
			end
		end else if (tState == 3'd3 && opcode == cpuPkg::opHalt) begin
			busy <= 1'b0;
			halted <= 1'b1;
		end else begin
			tState <= lastStep ? 3'd0 : tState + 3'd1;
		end
	end

	always_comb begin
		{pcIn, irIn, marIn, mdrIn, yIn, zIn} = '0;
		{pcOut, mdrOut, zOut, cOut, regOut} = '0;
		{regIn, gra, grb, grc, baOut} = '0;
		{memRead, memWrite, incPc} = '0;
		aluOp = cpuPkg::aluPassB;
		if (busy) begin
			case (tState)
				3'd0: begin
					{pcOut, marIn, incPc, zIn} = '1;
					aluOp = cpuPkg::aluAdd;
				end
				3'd1: {zOut, pcIn, memRead, mdrIn} = '1;
				3'd2: {mdrOut, irIn} = '1;
				3'd3: begin
					if (opcode != cpuPkg::opHalt) begin
						{grb, regOut, yIn} = '1;
						baOut = useConst; // R0 is a zero base for ld, st and addi
					end
				end
				3'd4: begin
					if (useConst) cOut = 1'b1;
					else {grc, regOut} = '1;
					zIn = 1'b1;
					aluOp = execOp;
				end
				3'd5: begin
					zOut = 1'b1;
					if (memOp) marIn = 1'b1;
					else {gra, regIn} = '1;
				end
				3'd6: begin
					mdrIn = 1'b1;
					if (opcode == cpuPkg::opSt) {gra, regOut, memWrite} = '1;
					else memRead = 1'b1;
				end
				3'd7: {mdrOut, gra, regIn} = '1;
			endcase
		end
	end

endmodule

// ==== design/wordMemory.sv ====
`timescale 1ns/100ps

module wordMemory (
	input logic Clock,
	input logic [cpuPkg::addrWidth-1:0] cpuAddr,
	input logic cpuWrite,
	input logic [cpuPkg::dataWidth-1:0] cpuWdata,
	output logic [cpuPkg::dataWidth-1:0] cpuRdata,
	input logic [cpuPkg::addrWidth-1:0] hostAddr,
	input logic hostWrite,
	input logic [cpuPkg::dataWidth-1:0] hostWdata,
	output logic [cpuPkg::dataWidth-1:0] hostRdata
);
	logic [cpuPkg::dataWidth-1:0] mem [1 << cpuPkg::addrWidth];

	// Host writes are refused while the core runs, so the ports never collide
	always_ff @(posedge Clock) begin
		if (cpuWrite) mem[cpuAddr] <= cpuWdata;
		if (hostWrite) mem[hostAddr] <= hostWdata;
	end

	assign cpuRdata = mem[cpuAddr];
	assign hostRdata = mem[hostAddr];

endmodule

// ==== design/hostRegs.sv ====
`timescale 1ns/100ps

module hostRegs (
	input logic Clock,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [4:0] paddr,
	input logic [cpuPkg::dataWidth-1:0] pwdata,
	output logic [cpuPkg::dataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	input logic halted,
	output logic start,
	output logic [cpuPkg::addrWidth-1:0] startPc,
	output logic [cpuPkg::addrWidth-1:0] memAddr,
	output logic memWrite,
	output logic [cpuPkg::dataWidth-1:0] memWdata,
	input logic [cpuPkg::dataWidth-1:0] memRdata,
	output logic [cpuPkg::regSelWidth-1:0] regSel,
	input logic [cpuPkg::dataWidth-1:0] regData
);
	logic access;
	logic known;
	logic window;
	logic writeOk;

	assign access = psel && penable;
	assign window = paddr == cpuPkg::regMemData || paddr == cpuPkg::regRegData;
	assign pslverr = access && (!known || (window && busy));
	assign writeOk = access && pwrite && !pslverr;
	assign pready = 1'b1;
	assign memWrite = writeOk && paddr == cpuPkg::regMemData;
	assign memWdata = pwdata;

	always_comb begin
		known = 1'b1;
		prdata = '0;
		case (paddr)
			cpuPkg::regCtrl: prdata = '0; // Start bit is write only
			cpuPkg::regStatus: prdata[1:0] = {halted, busy};
			cpuPkg::regStartPc: prdata[cpuPkg::addrWidth-1:0] = startPc;
			cpuPkg::regMemAddr: prdata[cpuPkg::addrWidth-1:0] = memAddr;
			cpuPkg::regMemData: prdata = memRdata;
			cpuPkg::regRegSel: prdata[cpuPkg::regSelWidth-1:0] = regSel;
			cpuPkg::regRegData: prdata = regData;
			default: known = 1'b0;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			start <= 1'b0;
			startPc <= '0;
			memAddr <= '0;
			regSel <= '0;
		end else begin
			start <= writeOk && paddr == cpuPkg::regCtrl && pwdata[0];
			if (writeOk) begin
				case (paddr)
					cpuPkg::regStartPc: startPc <= pwdata[cpuPkg::addrWidth-1:0];
					cpuPkg::regMemAddr: memAddr <= pwdata[cpuPkg::addrWidth-1:0];
					cpuPkg::regMemData: memAddr <= memAddr + 1'b1; // Burst loads walk forward
					cpuPkg::regRegSel: regSel <= pwdata[cpuPkg::regSelWidth-1:0];
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== design/cpuTop.sv ====
`timescale 1ns/100ps

module cpuTop (
	input logic Clock,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [4:0] paddr,
	input logic [cpuPkg::dataWidth-1:0] pwdata,
	output logic [cpuPkg::dataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	logic pcIn, irIn, marIn, mdrIn, yIn, zIn;
	logic pcOut, mdrOut, zOut, cOut, regOut;
	logic regIn, gra, grb, grc, baOut;
	logic memRead, memWrite, incPc;
	cpuPkg::aluOpT aluOp;
	cpuPkg::instrWord ir;
	logic busy;
	logic halted;
	logic start;
	logic hostWrite;
	logic [cpuPkg::addrWidth-1:0] startPc;
	logic [cpuPkg::addrWidth-1:0] cpuAddr;
	logic [cpuPkg::addrWidth-1:0] hostAddr;
	logic [cpuPkg::dataWidth-1:0] mdrValue;
	logic [cpuPkg::dataWidth-1:0] cpuRdata;
	logic [cpuPkg::dataWidth-1:0] hostWdata;
	logic [cpuPkg::dataWidth-1:0] hostRdata;
	logic [cpuPkg::dataWidth-1:0] regData;
	logic [cpuPkg::regSelWidth-1:0] regSel;

	hostRegs u_host (
		.*,
		.memAddr(hostAddr),
		.memWrite(hostWrite),
		.memWdata(hostWdata),
		.memRdata(hostRdata)
	);

	controlSequencer u_seq (.*);

	busDatapath u_path (
		.*,
		.startLoad(start),
		.memData(cpuRdata),
		.memAddr(cpuAddr)
	);

	wordMemory u_mem (
		.Clock(Clock),
		.cpuAddr(cpuAddr),
		.cpuWrite(memWrite),
		.cpuWdata(mdrValue),
		.cpuRdata(cpuRdata),
		.hostAddr(hostAddr),
		.hostWrite(hostWrite),
		.hostWdata(hostWdata),
		.hostRdata(hostRdata)
	);

endmodule

// ==== bench/cpuTopTb.sv ====
`timescale 1ns/100ps

module cpuTopTb;
	localparam int clockPeriod = 100;
	localparam int driveDelay = 10;
	localparam int sampleDelay = 40; // Access phase is read mid-cycle
	localparam int resetCycles = 16;
	localparam int apbCycles = 3; // Setup, access and one idle cycle
	localparam int readyLimit = 8;
	localparam int burstLength = 16;
	// Transfers per test come to about 34, 51, 69, 75 and 75 with the status polls
	localparam int transferBudget = 350;
	localparam int marginCycles = 200;
	localparam int watchdogCycles = resetCycles + apbCycles * transferBudget + marginCycles;
	localparam logic [31:0] lfsrSeed = 32'd99147;
	localparam logic [31:0] lfsrTaps = 32'h80200003;

	logic Clock = 1'b0;
	logic rst = 1'b1;
	logic psel = 1'b0;
	logic penable = 1'b0;
	logic pwrite = 1'b0;
	logic [4:0] paddr = '0;
	logic [cpuPkg::dataWidth-1:0] pwdata = '0;
	logic [cpuPkg::dataWidth-1:0] prdata;
	logic pready;
	logic pslverr;

	logic [31:0] lfsrState = lfsrSeed;
	logic [cpuPkg::dataWidth-1:0] regModel [cpuPkg::regCount];
	logic [cpuPkg::dataWidth-1:0] memModel [1 << cpuPkg::addrWidth];
	logic [cpuPkg::dataWidth-1:0] progWords [$];
	int progCycles = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;

	always #(clockPeriod / 2) Clock = ~Clock;

	cpuTop u_dut (.*);

	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0]) return (state >> 1) ^ lfsrTaps;
		return state >> 1;
	endfunction

	task automatic randomBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic checkWord(input string name, input logic [cpuPkg::dataWidth-1:0] actual,
			input logic [cpuPkg::dataWidth-1:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic busTransfer(input logic write, input logic [4:0] addr,
			input logic [cpuPkg::dataWidth-1:0] wdata,
			output logic [cpuPkg::dataWidth-1:0] rdata, output logic err);
		int waits;
		@(posedge Clock);
		#driveDelay;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge Clock);
		#driveDelay;
		penable = 1'b1;
		#sampleDelay;
		waits = 0;
		while (pready !== 1'b1 && waits < readyLimit) begin
			@(posedge Clock);
			#(driveDelay + sampleDelay);
			waits++;
		end
		if (pready !== 1'b1) begin
			errorCount++;
			$display("APB transfer to offset %h saw no pready within %0d cycles", addr, readyLimit);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge Clock);
		#driveDelay;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbWrite(input logic [4:0] addr, input logic [cpuPkg::dataWidth-1:0] data,
			input logic expectErr);
		logic [cpuPkg::dataWidth-1:0] ignored;
		logic err;
		busTransfer(1'b1, addr, data, ignored, err);
		checkFlag($sformatf("pslverr on write to %h", addr), err, expectErr);
	endtask

	task automatic apbRead(input logic [4:0] addr, output logic [cpuPkg::dataWidth-1:0] data,
			input logic expectErr);
		logic err;
		busTransfer(1'b0, addr, '0, data, err);
		checkFlag($sformatf("pslverr on read of %h", addr), err, expectErr);
	endtask

	task automatic writeMemWord(input int addr, input logic [cpuPkg::dataWidth-1:0] data);
		apbWrite(cpuPkg::regMemAddr, addr, 1'b0);
		apbWrite(cpuPkg::regMemData, data, 1'b0);
		memModel[addr] = data;
	endtask

	task automatic readMemWord(input int addr, output logic [cpuPkg::dataWidth-1:0] data);
		apbWrite(cpuPkg::regMemAddr, addr, 1'b0);
		apbRead(cpuPkg::regMemData, data, 1'b0);
	endtask

	task automatic checkRegs();
		logic [cpuPkg::dataWidth-1:0] data;
		for (int i = 0; i < cpuPkg::regCount; i++) begin
			apbWrite(cpuPkg::regRegSel, i, 1'b0);
			apbRead(cpuPkg::regRegData, data, 1'b0);
			checkWord($sformatf("R%0d", i), data, regModel[i]);
		end
	endtask

	task automatic newProgram();
		progWords.delete();
		progCycles = 0;
	endtask

	// Each instruction updates the reference model as it is appended
	task automatic aluInstr(input cpuPkg::opcodeT op, input int ra, input int rb, input int rc);
		logic [cpuPkg::dataWidth-1:0] b;
		logic [cpuPkg::dataWidth-1:0] c;
		b = regModel[rb[3:0]];
		c = regModel[rc[3:0]];
		progWords.push_back({op, ra[3:0], rb[3:0], rc[3:0], 15'b0});
		progCycles += 6;
		case (op)
			cpuPkg::opAdd: regModel[ra[3:0]] = b + c;
			cpuPkg::opSub: regModel[ra[3:0]] = b - c;
			cpuPkg::opAnd: regModel[ra[3:0]] = b & c;
			default: regModel[ra[3:0]] = b | c;
		endcase
	endtask

	task automatic constInstr(input cpuPkg::opcodeT op, input int ra, input int rb, input int c);
		logic [cpuPkg::dataWidth-1:0] base;
		logic [cpuPkg::dataWidth-1:0] sum;
		logic [cpuPkg::addrWidth-1:0] addr;
		base = '0; // R0 is a zero base here
		if (rb[3:0] != 4'd0) base = regModel[rb[3:0]];
		sum = base + {{13{c[18]}}, c[18:0]};
		addr = sum[cpuPkg::addrWidth-1:0];
		progWords.push_back({op, ra[3:0], rb[3:0], c[18:0]});
		case (op)
			cpuPkg::opLd: begin
				regModel[ra[3:0]] = memModel[addr];
				progCycles += 8;
			end
			cpuPkg::opSt: begin
				memModel[addr] = regModel[ra[3:0]];
				progCycles += 7;
			end
			default: begin
				regModel[ra[3:0]] = sum;
				progCycles += 6;
			end
		endcase
	endtask

	task automatic haltInstr();
		progWords.push_back({cpuPkg::opHalt, 27'b0});
		progCycles += 4;
	endtask

	task automatic loadProgram(input int base);
		apbWrite(cpuPkg::regMemAddr, base, 1'b0);
		foreach (progWords[i]) begin
			apbWrite(cpuPkg::regMemData, progWords[i], 1'b0);
			memModel[base + i] = progWords[i];
		end
	endtask

	task automatic startRun(input int base);
		logic [cpuPkg::dataWidth-1:0] status;
		apbWrite(cpuPkg::regStartPc, base, 1'b0);
		apbWrite(cpuPkg::regCtrl, 32'd1, 1'b0);
		apbRead(cpuPkg::regStatus, status, 1'b0);
		checkFlag("busy after start", status[0], 1'b1);
	endtask

	task automatic waitHalted();
		logic [cpuPkg::dataWidth-1:0] status;
		int polls;
		int pollLimit;
		pollLimit = progCycles / apbCycles + 4;
		polls = 0;
		status = '0;
		while (status[1] !== 1'b1 && polls < pollLimit) begin
			apbRead(cpuPkg::regStatus, status, 1'b0);
			polls++;
		end
		if (status[1] !== 1'b1) begin
			errorCount++;
			$display("The core did not halt within %0d status polls", pollLimit);
		end else begin
			checkFlag("busy after halt", status[0], 1'b0);
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) $display("%-14s ok", name);
		else $display("%-14s %0d errors", name, errorCount - errorsBefore);
	endtask

	task automatic resetState();
		logic [cpuPkg::dataWidth-1:0] data;
		int errorsBefore;
		errorsBefore = errorCount;
		apbRead(cpuPkg::regStatus, data, 1'b0);
		checkWord("status", data, '0);
		apbRead(cpuPkg::regStartPc, data, 1'b0);
		checkWord("startPc", data, '0);
		checkRegs();
		reportTest("resetState", errorsBefore);
	endtask

	task automatic memoryWindow();
		logic [cpuPkg::dataWidth-1:0] word;
		logic [cpuPkg::dataWidth-1:0] data;
		int base;
		int errorsBefore;
		errorsBefore = errorCount;
		base = 'h40;
		apbWrite(cpuPkg::regMemAddr, base, 1'b0);
		for (int i = 0; i < burstLength; i++) begin
			randomBits(cpuPkg::dataWidth, word);
			apbWrite(cpuPkg::regMemData, word, 1'b0);
			memModel[base + i] = word;
		end
		apbRead(cpuPkg::regMemAddr, data, 1'b0);
		checkWord("memAddr after burst", data, base + burstLength);
		for (int i = 0; i < burstLength; i++) begin
			readMemWord(base + i, data);
			checkWord($sformatf("mem[%h]", base + i), data, memModel[base + i]);
		end
		apbRead(5'h1C, data, 1'b1); // No register at this offset
		reportTest("memoryWindow", errorsBefore);
	endtask

	task automatic aluProgram();
		logic [31:0] c [4];
		int errorsBefore;
		errorsBefore = errorCount;
		for (int i = 0; i < 4; i++) begin
			randomBits(19, c[i]);
		end
		newProgram();
		constInstr(cpuPkg::opAddi, 0, 0, c[0]); // R0 holds a value from here on
		constInstr(cpuPkg::opAddi, 1, 0, c[1]);
		constInstr(cpuPkg::opAddi, 2, 0, c[2]);
		constInstr(cpuPkg::opAddi, 3, 1, c[3]);
		aluInstr(cpuPkg::opAdd, 4, 1, 2);
		aluInstr(cpuPkg::opSub, 5, 3, 2);
		aluInstr(cpuPkg::opAnd, 6, 4, 5);
		aluInstr(cpuPkg::opOr, 7, 6, 1);
		aluInstr(cpuPkg::opAdd, 8, 0, 3); // Without baOut R0 is read as stored
		haltInstr();
		loadProgram('h00);
		startRun('h00);
		waitHalted();
		checkRegs();
		reportTest("aluProgram", errorsBefore);
	endtask

	task automatic loadStore();
		logic [31:0] c [2];
		logic [cpuPkg::dataWidth-1:0] word;
		logic [cpuPkg::dataWidth-1:0] data;
		int errorsBefore;
		errorsBefore = errorCount;
		randomBits(19, c[0]);
		randomBits(19, c[1]);
		randomBits(cpuPkg::dataWidth, word);
		writeMemWord('h108, word);
		newProgram();
		constInstr(cpuPkg::opAddi, 9, 0, 'h100);
		constInstr(cpuPkg::opAddi, 10, 0, c[0]);
		constInstr(cpuPkg::opAddi, 11, 0, c[1]);
		constInstr(cpuPkg::opSt, 10, 9, 5);
		constInstr(cpuPkg::opSt, 11, 9, -3);
		constInstr(cpuPkg::opLd, 12, 9, 5);
		constInstr(cpuPkg::opLd, 13, 9, -3);
		constInstr(cpuPkg::opLd, 14, 9, 8); // Word placed by the host
		haltInstr();
		loadProgram('h80);
		startRun('h80);
		waitHalted();
		checkRegs();
		readMemWord('h105, data);
		checkWord("mem[105]", data, memModel['h105]);
		readMemWord('hFD, data);
		checkWord("mem[0fd]", data, memModel['hFD]);
		reportTest("loadStore", errorsBefore);
	endtask

	task automatic busyAccess();
		logic [cpuPkg::dataWidth-1:0] guard;
		logic [cpuPkg::dataWidth-1:0] data;
		int guardAddr;
		int errorsBefore;
		errorsBefore = errorCount;
		guardAddr = 'h140;
		randomBits(cpuPkg::dataWidth, guard);
		writeMemWord(guardAddr, guard);
		newProgram();
		for (int i = 0; i < 8; i++) begin
			constInstr(cpuPkg::opAddi, i + 1, i, i + 1);
		end
		haltInstr();
		loadProgram('hC0);
		apbWrite(cpuPkg::regMemAddr, guardAddr, 1'b0);
		startRun('hC0);
		apbWrite(cpuPkg::regMemData, ~guard, 1'b1);
		apbRead(cpuPkg::regMemData, data, 1'b1);
		apbRead(cpuPkg::regRegData, data, 1'b1);
		waitHalted();
		apbRead(cpuPkg::regStatus, data, 1'b0);
		checkFlag("halted", data[1], 1'b1);
		checkFlag("busy", data[0], 1'b0);
		apbRead(cpuPkg::regMemAddr, data, 1'b0);
		checkWord("memAddr after refused write", data, guardAddr);
		apbRead(cpuPkg::regMemData, data, 1'b0);
		checkWord("guard word", data, guard);
		checkRegs();
		reportTest("busyAccess", errorsBefore);
	endtask

	initial begin
		foreach (regModel[i]) begin
			regModel[i] = '0;
		end
		repeat (resetCycles) @(posedge Clock);
		#driveDelay;
		rst = 1'b0;
		resetState();
		memoryWindow();
		aluProgram();
		loadStore();
		busyAccess();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Watchdog expired after %0d cycles with tests still running", watchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
design/cpuPkg.sv
design/registerFile.sv
design/aluUnit.sv
design/busDatapath.sv
design/controlSequencer.sv
design/wordMemory.sv
design/hostRegs.sv
design/cpuTop.sv
bench/cpuTopTb.sv

// ==== Bender.yml ====
package:
  name: bus_cpu

sources:
  - design/cpuPkg.sv
  - design/registerFile.sv
  - design/aluUnit.sv
  - design/busDatapath.sv
  - design/controlSequencer.sv
  - design/wordMemory.sv
  - design/hostRegs.sv
  - design/cpuTop.sv
  - target: simulation
    files:
      - bench/cpuTopTb.sv
